/* vlog.f */
hw/udma_pkg.sv
hw/udma_apb_if.sv
hw/udma_ctrl.sv
hw/udma_rx_chan.sv
hw/udma_rx_channels.sv
hw/udma_core.sv
tests/tb_udma_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the micro-DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_udma_core -o sim_tb_udma_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_udma_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* tests/tb_udma_core.sv */
// Directed testbench of the micro-DMA core
// Clock, reset, APB and stream driver tasks, an L2 model with random
// grant delays, the tests and the cycle timeout

`default_nettype none

module tb_udma_core
    import udma_pkg::*;
;
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic rst_n;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    data_t pwdata;
    logic pwrite;
    logic psel;
    logic penable;
    data_t prdata;
    logic pready;
    logic pslverr;
    logic event_valid;
    logic [7:0] event_data;
    logic [N_EVENTS-1:0] event_out;
    logic [N_PERIPHS-1:0] clk_en;
    periph_req_t periph_req;
    logic [N_PERIPHS-1:0] periph_valid;
    data_t [N_PERIPHS-1:0] periph_data;
    logic [N_PERIPHS-1:0] periph_ready;
    rx_beat_t [N_RX_CHANNELS-1:0] rx_beat;
    logic [N_RX_CHANNELS-1:0] rx_ready;
    rx_cfg_t [N_RX_CHANNELS-1:0] rx_cfg;
    rx_status_t [N_RX_CHANNELS-1:0] rx_status;
    logic [N_RX_CHANNELS-1:0] rx_events;
    logic l2_req;
    l2_wr_t l2_wr;
    logic l2_gnt;

    logic rand_gnt;
    int cycles;
    int evt_cnt [N_RX_CHANNELS];
    l2_wr_t got_q[$];
    l2_wr_t exp_q[$];
    l2_wr_t exp_b_q[$];

    udma_core u_udma_core (
        .clk_i(clk), .rst_n_i(rst_n),
        .PADDR_i(paddr), .PWDATA_i(pwdata), .PWRITE_i(pwrite),
        .PSEL_i(psel), .PENABLE_i(penable),
        .PRDATA_o(prdata), .PREADY_o(pready), .PSLVERR_o(pslverr),
        .event_valid_i(event_valid), .event_data_i(event_data), .event_o(event_out),
        .periph_clk_en_o(clk_en),
        .periph_req_o(periph_req), .periph_valid_o(periph_valid),
        .periph_data_from_i(periph_data), .periph_ready_i(periph_ready),
        .rx_beat_i(rx_beat), .rx_ready_o(rx_ready), .rx_cfg_i(rx_cfg),
        .rx_status_o(rx_status), .rx_events_o(rx_events),
        .l2_req_o(l2_req), .l2_wr_o(l2_wr), .l2_gnt_i(l2_gnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Run stopped, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    //////////////////////////////
    // L2 and event monitors
    //////////////////////////////

    // The grant is chosen on the falling edge and the write is logged once it settles
    always
    begin
        @(negedge clk);
        l2_gnt = rand_gnt ? ($urandom_range(0, 2) == 0) : 1'b1;
        #10;
        if (l2_req && l2_gnt)
            got_q.push_back(l2_wr);
    end

    always @(negedge clk)
    begin
        for (int i = 0; i < N_RX_CHANNELS; i++)
            if (rx_events[i])
                evt_cnt[i] = evt_cnt[i] + 1;
    end

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////

    task automatic apb_xfer(input periph_id_t id, input periph_addr_t off, input logic wr,
                            input data_t wdata, output data_t rdata);
        logic done;
        done = 1'b0;
        @(negedge clk);
        paddr  = {id, off, 2'b00};
        pwrite = wr;
        pwdata = wdata;
        psel   = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        while (!done)
        begin
            #10;
            if (pready)
            begin
                rdata = prdata;
                done  = 1'b1;
            end
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_beat(input int ch, input data_t data, input datasize_t ds);
        logic done;
        done = 1'b0;
        @(negedge clk);
        rx_beat[ch] = '{data: data, datasize: ds, valid: 1'b1};
        while (!done)
        begin
            #10;
            done = rx_ready[ch];
            @(negedge clk);
        end
        rx_beat[ch].valid = 1'b0;
    endtask

    task automatic start_chan(input int ch, input byte_addr_t start, input trans_size_t size,
                              input logic cont);
        @(negedge clk);
        rx_cfg[ch] = '{start_addr: start, size: size, continuous: cont, en: 1'b1, clr: 1'b0};
        @(negedge clk);
        rx_cfg[ch].en = 1'b0;
    endtask

    // Expected L2 word from the lane rule of the byte address and datasize
    function automatic l2_wr_t lane_word(input byte_addr_t a, input datasize_t ds, input data_t d);
        l2_wr_t w;
        int     nbytes;
        nbytes = 1 << ds;
        w.addr = a[L2_AWIDTH_NOAL-1:2];
        // A beat owns the lanes of its aligned group and its bytes repeat across the word
        for (int lane = 0; lane < 4; lane++)
        begin
            w.be[lane]           = (lane / nbytes) == (int'(a[1:0]) / nbytes);
            w.wdata[8*lane +: 8] = d[8*(lane % nbytes) +: 8];
        end
        return w;
    endfunction

    task automatic wait_writes(input int n);
        while (got_q.size() < n)
            @(negedge clk);
    endtask

    task automatic compare_writes(input string what);
        l2_wr_t g;
        while (exp_q.size() > 0)
        begin
            g = got_q.pop_front();
            check_val(what, 64'(g), 64'(exp_q.pop_front()));
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic ctrl_regs_test();
        data_t rd;
        apb_xfer(5'd15, 5'd0, 1'b1, 32'h0000_000A, rd);
        apb_xfer(5'd15, 5'd1, 1'b1, 32'h4433_2211, rd);
        apb_xfer(5'd15, 5'd0, 1'b0, '0, rd);
        check_val("clock-enable readback", 64'(rd), 64'h0A);
        check_val("clock-enable output", 64'(clk_en), 64'hA);
        apb_xfer(5'd15, 5'd1, 1'b0, '0, rd);
        check_val("event-select readback", 64'(rd), 64'h4433_2211);
        apb_xfer(5'd9, 5'd1, 1'b0, '0, rd);
        check_val("unmapped read", 64'(rd), 64'h0);
    endtask

    task automatic ext_slot_test();
        data_t rd;
        periph_data[2]  = 32'hCAFE_0002;
        periph_ready[2] = 1'b0;
        fork
            apb_xfer(5'd2, 5'd7, 1'b1, 32'h1234_5678, rd);
            begin
                repeat (3) @(negedge clk);
                #20;
                check_val("slot 2 valid", 64'(periph_valid), 64'h4);
                check_val("slot 2 offset", 64'(periph_req.addr), 64'd7);
                check_val("slot 2 wdata", 64'(periph_req.wdata), 64'h1234_5678);
                check_val("slot 2 rwn", 64'(periph_req.rwn), 64'h0);
                check_val("PREADY held low", 64'(pready), 64'h0);
                check_val("PSLVERR low", 64'(pslverr), 64'h0);
                @(negedge clk);
                periph_ready[2] = 1'b1;
            end
        join
        check_val("slot 2 read data", 64'(rd), 64'hCAFE_0002);
        periph_ready[2] = 1'b0;
    endtask

    task automatic event_test();
        logic [7:0] codes [5];
        logic [3:0] expect_evt [5];
        codes      = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
        expect_evt = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0000};
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            event_valid = 1'b1;
            event_data  = codes[i];
            @(negedge clk);
            event_valid = 1'b0;
            check_val("event pulse", 64'(event_out), 64'(expect_evt[i]));
            @(negedge clk);
            check_val("event pulse end", 64'(event_out), 64'h0);
        end
    endtask

    task automatic word_xfer_test();
        data_t d;
        int ev;
        ev = evt_cnt[0];
        start_chan(0, 17'h40, 16'd16, 1'b0);
        for (int i = 0; i < 4; i++)
        begin
            d = $urandom;
            exp_q.push_back(lane_word(17'h40 + 17'(4 * i), 2'd2, d));
            send_beat(0, d, 2'd2);
        end
        wait_writes(4);
        compare_writes("word transfer");
        repeat (2) @(negedge clk);
        check_val("word transfer event", 64'(evt_cnt[0] - ev), 64'd1);
        check_val("channel 0 idle", 64'(rx_status[0].en), 64'h0);
        check_val("bytes left", 64'(rx_status[0].bytes_left), 64'h0);
        check_val("current address", 64'(rx_status[0].curr_addr), 64'h50);
    endtask

    task automatic lane_test();
        data_t d;
        start_chan(1, 17'h61, 16'd3, 1'b0);
        for (int i = 0; i < 3; i++)
        begin
            d = $urandom;
            exp_q.push_back(lane_word(17'h61 + 17'(i), 2'd0, d));
            send_beat(1, d, 2'd0);
        end
        start_chan(1, 17'h72, 16'd4, 1'b0);
        for (int i = 0; i < 2; i++)
        begin
            d = $urandom;
            exp_q.push_back(lane_word(17'h72 + 17'(2 * i), 2'd1, d));
            send_beat(1, d, 2'd1);
        end
        wait_writes(5);
        compare_writes("byte and halfword lanes");
    endtask

    task automatic dual_stream_test();
        data_t d;
        l2_wr_t g;
        int ev0;
        int ev1;
        ev0      = evt_cnt[0];
        ev1      = evt_cnt[1];
        rand_gnt = 1'b1;
        start_chan(0, 17'h100, 16'd8, 1'b1);
        start_chan(1, 17'h200, 16'd12, 1'b0);
        fork
            for (int i = 0; i < 4; i++)
            begin
                d = $urandom;
                exp_q.push_back(lane_word(17'h100 + 17'((4 * i) % 8), 2'd2, d));
                send_beat(0, d, 2'd2);
            end
            for (int j = 0; j < 3; j++)
            begin
                exp_b_q.push_back(lane_word(17'h200 + 17'(4 * j), 2'd2, 32'hB000_0000 + j));
                send_beat(1, 32'hB000_0000 + j, 2'd2);
            end
        join
        wait_writes(7);
        // Writes below word 0x80 come from channel 0
        while (got_q.size() > 0)
        begin
            g = got_q.pop_front();
            if (g.addr < 15'h80)
                check_val("channel 0 stream", 64'(g), 64'(exp_q.pop_front()));
            else
                check_val("channel 1 stream", 64'(g), 64'(exp_b_q.pop_front()));
        end
        check_val("channel 0 writes left", 64'(exp_q.size()), 64'd0);
        check_val("channel 1 writes left", 64'(exp_b_q.size()), 64'd0);
        check_val("continuous events", 64'(evt_cnt[0] - ev0), 64'd2);
        check_val("channel 1 events", 64'(evt_cnt[1] - ev1), 64'd1);
        check_val("continuous still running", 64'(rx_status[0].en), 64'h1);
        @(negedge clk);
        rx_cfg[0].clr = 1'b1;
        @(negedge clk);
        rx_cfg[0].clr = 1'b0;
        check_val("cleared channel idle", 64'(rx_status[0].en), 64'h0);
        check_val("cleared channel ready", 64'(rx_ready[0]), 64'h0);
        rand_gnt = 1'b0;
    endtask

    initial
    begin
        void'($urandom(57000));
        cycles       = 0;
        rst_n        = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        pwrite       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        event_valid  = 1'b0;
        event_data   = '0;
        periph_data  = '0;
        periph_ready = '0;
        rx_beat      = '0;
        rx_cfg       = '0;
        l2_gnt       = 1'b0;
        rand_gnt     = 1'b0;
        evt_cnt[0]   = 0;
        evt_cnt[1]   = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        ctrl_regs_test();
        ext_slot_test();
        event_test();
        word_xfer_test();
        lane_test();
        dual_stream_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/udma_core.sv */
// Top level of the micro-DMA core
// APB slave, control unit and receive channel array, with the
// external peripheral slots merged next to the control slot

`default_nettype none

module udma_core
    import udma_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [APB_ADDR_WIDTH-1:0]         PADDR_i,
    input  data_t                             PWDATA_i,
    input  logic                              PWRITE_i,
    input  logic                              PSEL_i,
    input  logic                              PENABLE_i,
    output data_t                             PRDATA_o,
    output logic                              PREADY_o,
    output logic                              PSLVERR_o,

    input  logic                              event_valid_i,
    input  logic [7:0]                        event_data_i,
    output logic [N_EVENTS-1:0]               event_o,

    output logic [N_PERIPHS-1:0]              periph_clk_en_o,

    output periph_req_t                       periph_req_o,
    output logic [N_PERIPHS-1:0]              periph_valid_o,
    input  data_t [N_PERIPHS-1:0]             periph_data_from_i,
    input  logic [N_PERIPHS-1:0]              periph_ready_i,

    input  rx_beat_t   [N_RX_CHANNELS-1:0]    rx_beat_i,
    output logic       [N_RX_CHANNELS-1:0]    rx_ready_o,
    input  rx_cfg_t    [N_RX_CHANNELS-1:0]    rx_cfg_i,
    output rx_status_t [N_RX_CHANNELS-1:0]    rx_status_o,
    output logic       [N_RX_CHANNELS-1:0]    rx_events_o,

    output logic                              l2_req_o,
    output l2_wr_t                            l2_wr_o,
    input  logic                              l2_gnt_i
);

    data_t [N_PERIPH_SLOTS-1:0] slot_data;
    logic  [N_PERIPH_SLOTS-1:0] slot_ready;
    logic  [N_PERIPH_SLOTS-1:0] slot_valid;
    data_t                      ctrl_rdata;
    logic                       ctrl_ready;

    // Slots without a peripheral stay at zero
    always_comb
    begin
        slot_data  = '0;
        slot_ready = '0;
        for (int i = 0; i < N_PERIPHS; i++)
        begin
            slot_data[i]  = periph_data_from_i[i];
            slot_ready[i] = periph_ready_i[i];
        end
        slot_data[CTRL_PERIPH_ID]  = ctrl_rdata;
        slot_ready[CTRL_PERIPH_ID] = ctrl_ready;
    end

    assign periph_valid_o = slot_valid[N_PERIPHS-1:0];

    udma_apb_if u_apb_if (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .PADDR_i        (PADDR_i),
        .PWDATA_i       (PWDATA_i),
        .PWRITE_i       (PWRITE_i),
        .PSEL_i         (PSEL_i),
        .PENABLE_i      (PENABLE_i),
        .PRDATA_o       (PRDATA_o),
        .PREADY_o       (PREADY_o),
        .PSLVERR_o      (PSLVERR_o),
        .periph_req_o   (periph_req_o),
        .periph_valid_o (slot_valid),
        .periph_data_i  (slot_data),
        .periph_ready_i (slot_ready)
    );

    udma_ctrl u_udma_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cfg_req_i     (periph_req_o),
        .cfg_valid_i   (slot_valid[CTRL_PERIPH_ID]),
        .cfg_data_o    (ctrl_rdata),
        .cfg_ready_o   (ctrl_ready),
        .cg_en_o       (periph_clk_en_o),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .event_o       (event_o)
    );

    udma_rx_channels u_rx_channels (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .cfg_i    (rx_cfg_i),
        .beat_i   (rx_beat_i),
        .ready_o  (rx_ready_o),
        .status_o (rx_status_o),
        .events_o (rx_events_o),
        .l2_req_o (l2_req_o),
        .l2_wr_o  (l2_wr_o),
        .l2_gnt_i (l2_gnt_i)
    );

endmodule

`default_nettype wire

/* hw/udma_rx_channels.sv */
// Receive channel array
// One engine per channel and a round-robin arbiter that presents
// one full buffer at a time on the L2 write port

`default_nettype none

module udma_rx_channels
    import udma_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  rx_cfg_t    [N_RX_CHANNELS-1:0]      cfg_i,
    input  rx_beat_t   [N_RX_CHANNELS-1:0]      beat_i,
    output logic       [N_RX_CHANNELS-1:0]      ready_o,
    output rx_status_t [N_RX_CHANNELS-1:0]      status_o,
    output logic       [N_RX_CHANNELS-1:0]      events_o,

    output logic                                l2_req_o,
    output l2_wr_t                              l2_wr_o,
    input  logic                                l2_gnt_i
);

    logic   [N_RX_CHANNELS-1:0] buf_full;
    logic   [N_RX_CHANNELS-1:0] buf_take;
    l2_wr_t [N_RX_CHANNELS-1:0] buf_data;

    logic [CHAN_IDX_WIDTH-1:0]  last_q;
    logic [CHAN_IDX_WIDTH-1:0]  lock_idx_q;
    logic                       lock_q;
    logic [CHAN_IDX_WIDTH-1:0]  rr_sel;
    logic [CHAN_IDX_WIDTH-1:0]  sel;

    for (genvar i = 0; i < N_RX_CHANNELS; i++)
    begin : g_chan
        udma_rx_chan u_rx_chan (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .cfg_i      (cfg_i[i]),
            .beat_i     (beat_i[i]),
            .ready_o    (ready_o[i]),
            .status_o   (status_o[i]),
            .event_o    (events_o[i]),
            .buf_full_o (buf_full[i]),
            .buf_o      (buf_data[i]),
            .buf_take_i (buf_take[i])
        );
    end

    //////////////////////////////
    // Round-robin arbiter
    //////////////////////////////

    // Search starts just after the channel served last
    always_comb
    begin
        int  idx;
        logic found;
        rr_sel = last_q;
        found  = 1'b0;
        for (int k = 1; k <= N_RX_CHANNELS; k++)
        begin
            idx = (int'(last_q) + k) % N_RX_CHANNELS;
            if (!found && buf_full[idx])
            begin
                rr_sel = CHAN_IDX_WIDTH'(idx);
                found  = 1'b1;
            end
        end
    end

    // A waiting request keeps its channel until granted or cleared
    assign sel = (lock_q && buf_full[lock_idx_q]) ? lock_idx_q : rr_sel;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            last_q     <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end
        else if (l2_req_o && l2_gnt_i)
        begin
            last_q <= sel;
            lock_q <= 1'b0;
        end
        else
        begin
            lock_q     <= l2_req_o;
            lock_idx_q <= sel;
        end
    end

    assign l2_req_o = |buf_full;
    assign l2_wr_o  = buf_data[sel];

    always_comb
    begin
        buf_take      = '0;
        buf_take[sel] = l2_req_o && l2_gnt_i;
    end

endmodule

`default_nettype wire

/* hw/udma_rx_chan.sv */
// Receive channel transfer engine
// IDLE/RUN machine with address and byte counters, lane placement
// of each beat and a one-entry buffer towards the L2 write port

`default_nettype none

module udma_rx_chan
    import udma_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  rx_cfg_t    cfg_i,
    input  rx_beat_t   beat_i,
    output logic       ready_o,
    output rx_status_t status_o,
    output logic       event_o,

    output logic       buf_full_o,
    output l2_wr_t     buf_o,
    input  logic       buf_take_i
);

    rx_state_e   state_q;
    byte_addr_t  addr_q;
    trans_size_t left_q;
    logic        full_q;
    logic        evt_q;
    l2_wr_t      buf_q;

    logic [2:0]  beat_bytes;
    logic        beat_fire;
    logic        beat_last;
    be_t         beat_be;
    data_t       beat_data;

    assign ready_o   = (state_q == RUN) && !full_q;
    assign beat_fire = beat_i.valid && ready_o;
    assign beat_last = left_q <= trans_size_t'(beat_bytes);

    // Lane placement of the beat from the low address bits
    always_comb
    begin
        case (beat_i.datasize)
            2'd0:
            begin
                beat_bytes = 3'd1;
                beat_be    = be_t'(4'b0001 << addr_q[1:0]);
                beat_data  = {4{beat_i.data[7:0]}};
            end
            2'd1:
            begin
                beat_bytes = 3'd2;
                beat_be    = addr_q[1] ? 4'b1100 : 4'b0011;
                beat_data  = {2{beat_i.data[15:0]}};
            end
            default:
            begin
                beat_bytes = 3'd4;
                beat_be    = 4'b1111;
                beat_data  = beat_i.data;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            full_q  <= 1'b0;
            evt_q   <= 1'b0;
        end
        else
        begin
            evt_q <= beat_fire && beat_last;
            if (cfg_i.clr)
            begin
                state_q <= IDLE;
                full_q  <= 1'b0;
            end
            else if (state_q == IDLE)
            begin
                if (buf_take_i)
                begin
                    full_q <= 1'b0;
                end
                if (cfg_i.en)
                begin
                    state_q <= RUN;
                    addr_q  <= cfg_i.start_addr;
                    left_q  <= cfg_i.size;
                end
            end
            else if (beat_fire)
            begin
                full_q <= 1'b1;
                if (!beat_last)
                begin
                    addr_q <= addr_q + byte_addr_t'(beat_bytes);
                    left_q <= left_q - trans_size_t'(beat_bytes);
                end
                else if (cfg_i.continuous)
                begin
                    addr_q <= cfg_i.start_addr;
                    left_q <= cfg_i.size;
                end
                else
                begin
                    state_q <= IDLE;
                    addr_q  <= addr_q + byte_addr_t'(beat_bytes);
                    left_q  <= '0;
                end
            end
            else if (buf_take_i)
            begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            buf_q <= '0;
        end
        else if (beat_fire)
        begin
            buf_q <= '{addr: addr_q[L2_AWIDTH_NOAL-1:2], be: beat_be, wdata: beat_data};
        end
    end

    assign buf_full_o = full_q;
    assign buf_o      = buf_q;
    assign event_o    = evt_q;

    assign status_o.en         = (state_q == RUN);
    assign status_o.curr_addr  = addr_q;
    assign status_o.bytes_left = left_q;

endmodule

`default_nettype wire

/* hw/udma_ctrl.sv */
// Control unit of the micro-DMA core
// Clock-enable register with one bit per peripheral, four
// event-select bytes and the registered event matching

`default_nettype none

module udma_ctrl
    import udma_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  periph_req_t          cfg_req_i,
    input  logic                 cfg_valid_i,
    output data_t                cfg_data_o,
    output logic                 cfg_ready_o,

    output logic [N_PERIPHS-1:0] cg_en_o,

    input  logic                 event_valid_i,
    input  logic [7:0]           event_data_i,
    output logic [N_EVENTS-1:0]  event_o
);

    logic [N_PERIPHS-1:0]          cg_en_q;
    logic [N_EVENTS-1:0][7:0]      evt_sel_q;
    logic [N_EVENTS-1:0]           evt_q;
    logic [N_EVENTS-1:0]           evt_match;
    logic                          wr_en;

    //////////////////////////////
    // Register file
    //////////////////////////////

    // The unit is always ready and a write lands on the first access edge
    assign cfg_ready_o = 1'b1;
    assign wr_en       = cfg_valid_i && !cfg_req_i.rwn;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cg_en_q   <= '0;
            evt_sel_q <= '0;
        end
        else if (wr_en)
        begin
            case (cfg_req_i.addr)
                CTRL_REG_CG:  cg_en_q   <= cfg_req_i.wdata[N_PERIPHS-1:0];
                CTRL_REG_EVT: evt_sel_q <= cfg_req_i.wdata;
                default:      ;
            endcase
        end
    end

    always_comb
    begin
        case (cfg_req_i.addr)
            CTRL_REG_CG:  cfg_data_o = data_t'(cg_en_q);
            CTRL_REG_EVT: cfg_data_o = evt_sel_q;
            default:      cfg_data_o = '0;
        endcase
    end

    assign cg_en_o = cg_en_q;

    //////////////////////////////
    // Event matching
    //////////////////////////////

    always_comb
    begin
        for (int k = 0; k < N_EVENTS; k++)
        begin
            evt_match[k] = event_valid_i && (event_data_i == evt_sel_q[k]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            evt_q <= '0;
        end
        else
        begin
            evt_q <= evt_match;
        end
    end

    assign event_o = evt_q;

endmodule

`default_nettype wire

/* hw/udma_apb_if.sv */
// APB slave of the micro-DMA core
// Turns APB accesses into peripheral configuration bus transfers
// and returns the selected slot's read data and ready

`default_nettype none

module udma_apb_if
    import udma_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [APB_ADDR_WIDTH-1:0]         PADDR_i,
    input  data_t                             PWDATA_i,
    input  logic                              PWRITE_i,
    input  logic                              PSEL_i,
    input  logic                              PENABLE_i,
    output data_t                             PRDATA_o,
    output logic                              PREADY_o,
    output logic                              PSLVERR_o,

    output periph_req_t                       periph_req_o,
    output logic [N_PERIPH_SLOTS-1:0]         periph_valid_o,
    input  data_t [N_PERIPH_SLOTS-1:0]        periph_data_i,
    input  logic [N_PERIPH_SLOTS-1:0]         periph_ready_i
);

    periph_id_t                        id;
    logic [$clog2(N_PERIPH_SLOTS)-1:0] slot_idx;
    logic                              access;
    logic                              mapped;

    // PADDR holds its value through the whole access
    assign id       = PADDR_i[11:7];
    assign access   = PSEL_i && PENABLE_i;
    assign mapped   = (id < N_PERIPHS) || (id == CTRL_PERIPH_ID);
    assign slot_idx = id[$clog2(N_PERIPH_SLOTS)-1:0];

    assign periph_req_o.wdata = PWDATA_i;
    assign periph_req_o.addr  = PADDR_i[6:2];
    assign periph_req_o.rwn   = !PWRITE_i;

    // Unmapped indices complete at once with zero read data
    always_comb
    begin
        periph_valid_o = '0;
        PRDATA_o       = '0;
        PREADY_o       = access;
        if (access && mapped)
        begin
            periph_valid_o[slot_idx] = 1'b1;
            PRDATA_o                 = periph_data_i[slot_idx];
            PREADY_o                 = periph_ready_i[slot_idx];
        end
    end

    assign PSLVERR_o = 1'b0;

endmodule

`default_nettype wire

/* hw/udma_pkg.sv */
// Shared definitions of the micro-DMA core
// Widths, counts, peripheral map and control register offsets,
// vector types, bus structs and the channel state enum

`default_nettype none

package udma_pkg;

    //////////////////////////////
    // Sizes and map
    //////////////////////////////

    localparam int APB_ADDR_WIDTH = 12;
    localparam int L2_ADDR_WIDTH  = 15;
    localparam int L2_AWIDTH_NOAL = 17;
    localparam int TRANS_SIZE     = 16;
    localparam int DATA_WIDTH     = 32;
    localparam int N_RX_CHANNELS  = 2;
    localparam int N_PERIPHS      = 4;
    localparam int CTRL_PERIPH_ID = 15;
    localparam int N_EVENTS       = 4;

    // Slots on the peripheral configuration bus
    localparam int N_PERIPH_SLOTS = 16;
    localparam int CHAN_IDX_WIDTH = $clog2(N_RX_CHANNELS);

    // Register offsets of the control unit
    localparam int CTRL_REG_CG    = 0;
    localparam int CTRL_REG_EVT   = 1;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [L2_AWIDTH_NOAL-1:0] byte_addr_t;
    typedef logic [L2_ADDR_WIDTH-1:0]  l2_addr_t;
    typedef logic [TRANS_SIZE-1:0]     trans_size_t;
    typedef logic [1:0]                datasize_t;
    typedef logic [DATA_WIDTH/8-1:0]   be_t;
    typedef logic [4:0]                periph_addr_t;
    typedef logic [4:0]                periph_id_t;

    typedef struct packed {
        data_t        wdata;
        periph_addr_t addr;
        logic         rwn;
    } periph_req_t;

    typedef struct packed {
        byte_addr_t  start_addr;
        trans_size_t size;
        logic        continuous;
        logic        en;
        logic        clr;
    } rx_cfg_t;

    typedef struct packed {
        logic        en;
        byte_addr_t  curr_addr;
        trans_size_t bytes_left;
    } rx_status_t;

    typedef struct packed {
        data_t     data;
        datasize_t datasize;
        logic      valid;
    } rx_beat_t;

    typedef struct packed {
        l2_addr_t addr;
        be_t      be;
        data_t    wdata;
    } l2_wr_t;

    typedef enum logic {
        IDLE,
        RUN
    } rx_state_e;

endpackage

`default_nettype wire
